//--- bench/tb_zigzag.sv
`timescale 1ns/1ps

module tb_zigzag import zz_pkg::*; ();

    localparam int tests_depth = 256;
    localparam int wait_limit  = 4000;
    localparam int stall_len   = 40;

    logic             clk = 1'b0;
    logic             resetn;
    coef_t            d_i;
    logic             d_valid_i;
    logic             d_hold_o;
    coef_t            q_o;
    logic [pos_w-1:0] q_idx_o;
    logic             q_valid_o;
    logic             q_hold_i;

    logic [15:0]       tests_mem [tests_depth];
    logic [pos_w-1:0]  zz_pos [blk_n];
    // raster-order coefficients in arrival order
    logic [coef_w-1:0] sb_q [$];
    bit                out_release;

    always #2 clk = ~clk;

    zigzag_buffer_top dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (d_i),
        .d_valid_i (d_valid_i),
        .d_hold_o  (d_hold_o),
        .q_o       (q_o),
        .q_idx_o   (q_idx_o),
        .q_valid_o (q_valid_o),
        .q_hold_i  (q_hold_i)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // everything in the bench happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [coef_w-1:0] raster_coef(int base, int step, int i);
        int v;
        v = base + step * i;
        return v[coef_w-1:0];
    endfunction

    task automatic drive_blocks(int n_blk, int base, int step, int gap_mode, int hold_mode);
        int waited;
        int n_gap;
        for (int i = 0; i < n_blk * blk_n; i++) begin
            if (gap_mode != 0) begin
                n_gap = $urandom_range(0, 3);
                d_valid_i = 1'b0;
                repeat (n_gap) next_cycle();
            end
            d_i = raster_coef(base, step, i);
            d_valid_i = 1'b1;
            if (hold_mode == 2 && i == 2 * blk_n) begin
                // two blocks buffered and the reader is stalled
                repeat (stall_len) begin
                    assert (d_hold_o) else abort_run("d_hold_o fell with both banks full");
                    next_cycle();
                end
                out_release = 1'b1;
            end
            waited = 0;
            while (d_hold_o) begin
                next_cycle();
                waited++;
                assert (waited < wait_limit) else abort_run("timeout waiting for d_hold_o to fall");
            end
            sb_q.push_back(raster_coef(base, step, i));
            next_cycle();
        end
        d_valid_i = 1'b0;
        out_release = 1'b1;
    endtask

    task automatic check_blocks(int n_blk, int hold_mode);
        logic [coef_w-1:0] blk [blk_n];
        logic [coef_w-1:0] exp_q;
        coef_t             held_q;
        logic [pos_w-1:0]  held_idx;
        bit                held;
        bit                taken;
        int                waited;
        for (int b = 0; b < n_blk; b++) begin
            for (int k = 0; k < blk_n; k++) begin
                held = 1'b0;
                taken = 1'b0;
                waited = 0;
                while (!taken) begin
                    case (hold_mode)
                        1: q_hold_i = ($urandom_range(0, 2) == 0);
                        2: q_hold_i = !out_release;
                        default: q_hold_i = 1'b0;
                    endcase
                    if (q_valid_o) begin
                        if (held) begin
                            assert (q_o == held_q) else abort_run($sformatf(
                                "error: q_o = 0x%03h under hold, expected 0x%03h", q_o, held_q));
                            assert (q_idx_o == held_idx) else abort_run($sformatf(
                                "error: q_idx_o = 0x%02h under hold, expected 0x%02h",
                                q_idx_o, held_idx));
                        end
                        held = q_hold_i;
                        held_q = q_o;
                        held_idx = q_idx_o;
                        taken = !q_hold_i;
                    end else begin
                        assert (!held) else abort_run("q_valid_o fell while q_hold_i was high");
                    end
                    if (!taken) begin
                        next_cycle();
                        waited++;
                        assert (waited < wait_limit) else abort_run("timeout waiting for q_valid_o");
                    end
                end
                if (k == 0) begin
                    assert (sb_q.size() >= blk_n)
                        else abort_run("output block started before its input was complete");
                    for (int p = 0; p < blk_n; p++) begin
                        blk[p] = sb_q.pop_front();
                    end
                end
                exp_q = blk[zz_pos[k]];
                assert (q_idx_o == pos_w'(k)) else abort_run($sformatf(
                    "error: q_idx_o = 0x%02h, expected 0x%02h", q_idx_o, k));
                assert (q_o == exp_q) else abort_run($sformatf(
                    "error: q_o = 0x%03h, expected 0x%03h", q_o, exp_q));
                next_cycle();
            end
        end
        q_hold_i = 1'b0;
    endtask

    initial begin
        int t;
        int n_blk;
        int base;
        int step;
        int gap_mode;
        int hold_mode;
        resetn = 1'b0;
        d_i = '0;
        d_valid_i = 1'b0;
        q_hold_i = 1'b0;
        out_release = 1'b0;
        void'($urandom(32'h73f0af6f));
        $readmemh("bench/zigzag_tests.txt", tests_mem);
        for (int k = 0; k < blk_n; k++) begin
            zz_pos[k] = tests_mem[k][pos_w-1:0];
        end
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        assert (q_valid_o == 1'b0) else abort_run($sformatf(
            "error: q_valid_o = 0x%h after reset, expected 0x0", q_valid_o));
        assert (d_hold_o == 1'b0) else abort_run($sformatf(
            "error: d_hold_o = 0x%h after reset, expected 0x0", d_hold_o));
        t = blk_n;
        // a zero block count ends the list
        while (t + 4 < tests_depth && tests_mem[t] != 0) begin
            n_blk = int'(tests_mem[t]);
            base = int'(tests_mem[t+1]);
            step = int'(tests_mem[t+2]);
            gap_mode = int'(tests_mem[t+3]);
            hold_mode = int'(tests_mem[t+4]);
            out_release = 1'b0;
            fork
                drive_blocks(n_blk, base, step, gap_mode, hold_mode);
                check_blocks(n_blk, hold_mode);
            join
            // no extra beat after the last block
            assert (q_valid_o == 1'b0) else abort_run($sformatf(
                "error: q_valid_o = 0x%h after the last beat, expected 0x0", q_valid_o));
            t += 5;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- bench/zigzag_tests.txt
// first 64 entries: raster position of zigzag index 0..63, eight per line
// then one test per line: blocks base step gap_mode hold_mode, all hex
// gap_mode 1 puts random idle cycles on the input
// hold_mode 1 is a random q_hold_i, 2 holds the output until the input stalls
00 01 08 10 09 02 03 0a
11 18 20 19 12 0b 04 05
0c 13 1a 21 28 30 29 22
1b 14 0d 06 07 0e 15 1c
23 2a 31 38 39 32 2b 24
1d 16 0f 17 1e 25 2c 33
3a 3b 34 2d 26 1f 27 2e
35 3c 3d 36 2f 37 3e 3f
// single block, no gaps, no hold
1 000 001 0 0
// several blocks with input gaps
4 123 005 1 0
// random output hold
3 7f0 011 0 1
3 050 003 1 1
// output held until both banks are full
4 200 007 0 2
3 0a0 013 1 2
// signed values wrapping past the sign bit
3 800 7ff 1 1
2 7ff 001 0 0
2 fff 555 0 1
// end of list
0 0 0 0 0

//--- block_writer/block_writer.sv
`timescale 1ns/1ps

module block_writer import zz_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  coef_t            d_i,
    input  logic             d_valid_i,
    output logic             d_hold_o,
    input  logic [ptr_w-1:0] rptr_i,
    output logic [ptr_w-1:0] wptr_o,
    mem_if.requester         mem
);

    logic              full;
    logic              accept;
    logic              busy_q;
    logic              req_q;
    logic [ptr_w-1:0]  wptr_q;
    logic [pos_w-1:0]  pos_q;
    logic [addr_w-1:0] addr_q;
    coef_t             wdata_q;

    // same bank, other lap
    assign full = (wptr_q[ptr_w-1] != rptr_i[ptr_w-1]) &&
                  (wptr_q[ptr_w-2:0] == rptr_i[ptr_w-2:0]);

    assign d_hold_o = busy_q || full;
    assign accept   = d_valid_i && !d_hold_o;
    assign wptr_o   = wptr_q;

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            wptr_q <= '0;
            pos_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            req_q  <= 1'b1;
            pos_q  <= pos_q + 1'b1;
        end else if (req_q && mem.ack) begin
            req_q <= 1'b0;
            // last coefficient of the block is in the RAM
            if (&addr_q[pos_w-1:0]) begin
                wptr_q <= wptr_q + 1'b1;
            end
        end else if (busy_q && !req_q && !mem.ack) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= {wptr_q[ptr_w-2:0], pos_q};
            wdata_q <= d_i;
        end
    end

    // ack drops one cycle after req falls
    a_ack_drop: assert property (@(posedge clk) disable iff (!resetn)
        (mem.ack && !mem.req) |=> !mem.ack);

endmodule

//--- common/mem_if.sv
`timescale 1ns/1ps

interface mem_if import zz_pkg::*; ();

    // four-phase handshake
    logic req;
    logic ack;

    logic              we;
    logic [addr_w-1:0] addr;
    coef_t             wdata;
    // valid while ack is high on a read
    coef_t             rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- common/zz_pkg.sv
package zz_pkg;

    // coefficient format out of the quantizer
    localparam int coef_w = 12;

    typedef logic signed [coef_w-1:0] coef_t;

    // one 8x8 block
    localparam int blk_n = 64;
    localparam int pos_w = 6;

    // bank bit on top of the in-block position
    localparam int bank_n = 2;
    localparam int addr_w = 7;

    // bank bit plus wrap bit
    localparam int ptr_w = 2;

    // who currently holds the RAM
    typedef enum logic [1:0] {
        own_none,
        own_wr,
        own_rd
    } owner_e;

    // zigzag reader FSM
    typedef enum logic [1:0] {
        rd_idle,
        rd_req,
        rd_wait,
        rd_out
    } rd_state_e;

endpackage

//--- logic/coef_ram.sv
`timescale 1ns/1ps

module coef_ram import zz_pkg::*; (
    input  logic              clk,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [addr_w-1:0] addr_i,
    input  coef_t             wdata_i,
    output coef_t             rdata_o
);

    // two banks of one block each
    coef_t mem [bank_n*blk_n];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
                // write-first
                rdata_o <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import zz_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    mem_if.arbiter            wr,
    mem_if.arbiter            rd,
    output logic              ram_en_o,
    output logic              ram_we_o,
    output logic [addr_w-1:0] ram_addr_o,
    output coef_t             ram_wdata_o,
    input  coef_t             ram_rdata_i
);

    owner_e            owner_q;
    logic              done_q;
    logic              ack_q;
    logic              last_rd_q;
    logic              cur_req;
    logic              cur_we;
    logic [addr_w-1:0] cur_addr;
    coef_t             cur_wdata;

    // granted port drives the RAM
    always_comb begin
        if (owner_q == own_rd) begin
            cur_req   = rd.req;
            cur_we    = rd.we;
            cur_addr  = rd.addr;
            cur_wdata = rd.wdata;
        end else begin
            cur_req   = wr.req;
            cur_we    = wr.we;
            cur_addr  = wr.addr;
            cur_wdata = wr.wdata;
        end
    end

    // one RAM cycle per grant
    assign ram_en_o    = (owner_q != own_none) && !done_q;
    assign ram_we_o    = cur_we;
    assign ram_addr_o  = cur_addr;
    assign ram_wdata_o = cur_wdata;

    assign wr.ack   = ack_q && (owner_q == own_wr);
    assign rd.ack   = ack_q && (owner_q == own_rd);
    assign wr.rdata = ram_rdata_i;
    assign rd.rdata = ram_rdata_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            owner_q   <= own_none;
            done_q    <= 1'b0;
            ack_q     <= 1'b0;
            last_rd_q <= 1'b0;
        end else if (owner_q == own_none) begin
            // alternate when both are waiting
            if (wr.req && (!rd.req || last_rd_q)) begin
                owner_q   <= own_wr;
                last_rd_q <= 1'b0;
            end else if (rd.req) begin
                owner_q   <= own_rd;
                last_rd_q <= 1'b1;
            end
        end else if (!done_q) begin
            done_q <= 1'b1;
        end else if (!ack_q && cur_req) begin
            // read data settled in the RAM output register
            ack_q <= 1'b1;
        end else if (ack_q && !cur_req) begin
            ack_q   <= 1'b0;
            done_q  <= 1'b0;
            owner_q <= own_none;
        end
    end

    // granted requester keeps req up until its ack
    a_req_kept: assert property (@(posedge clk) disable iff (!resetn)
        (owner_q != own_none && !ack_q) |-> cur_req);

endmodule

//--- logic/zigzag_buffer_top.sv
`timescale 1ns/1ps

module zigzag_buffer_top import zz_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  coef_t            d_i,
    input  logic             d_valid_i,
    output logic             d_hold_o,
    output coef_t            q_o,
    output logic [pos_w-1:0] q_idx_o,
    output logic             q_valid_o,
    input  logic             q_hold_i
);

    logic [ptr_w-1:0]  wptr;
    logic [ptr_w-1:0]  rptr;
    logic              ram_en;
    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    coef_t             ram_wdata;
    coef_t             ram_rdata;

    mem_if wr_bus ();
    mem_if rd_bus ();

    block_writer writer_i (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (d_i),
        .d_valid_i (d_valid_i),
        .d_hold_o  (d_hold_o),
        .rptr_i    (rptr),
        .wptr_o    (wptr),
        .mem       (wr_bus.requester)
    );

    zigzag_reader reader_i (
        .clk       (clk),
        .resetn    (resetn),
        .wptr_i    (wptr),
        .rptr_o    (rptr),
        .q_o       (q_o),
        .q_idx_o   (q_idx_o),
        .q_valid_o (q_valid_o),
        .q_hold_i  (q_hold_i),
        .mem       (rd_bus.requester)
    );

    mem_arbiter arbiter_i (
        .clk         (clk),
        .resetn      (resetn),
        .wr          (wr_bus.arbiter),
        .rd          (rd_bus.arbiter),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    coef_ram ram_i (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

//--- project.f
common/zz_pkg.sv
common/mem_if.sv
logic/coef_ram.sv
logic/mem_arbiter.sv
block_writer/block_writer.sv
zigzag_reader/zigzag_reader.sv
logic/zigzag_buffer_top.sv
bench/tb_zigzag.sv

//--- run_sim.sh
#!/bin/sh
# build and run the zigzag buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_zigzag \
    -f project.f \
    -o tb_zigzag

# exit status of the simulation is the test result
./obj_dir/tb_zigzag

//--- zigzag_reader/zigzag_reader.sv
`timescale 1ns/1ps

module zigzag_reader import zz_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic [ptr_w-1:0] wptr_i,
    output logic [ptr_w-1:0] rptr_o,
    output coef_t            q_o,
    output logic [pos_w-1:0] q_idx_o,
    output logic             q_valid_o,
    input  logic             q_hold_i,
    mem_if.requester         mem
);

    rd_state_e         state_q;
    logic              empty;
    logic              req_q;
    logic [ptr_w-1:0]  rptr_q;
    logic [pos_w-1:0]  idx_q;
    logic [addr_w-1:0] addr_q;
    coef_t             q_q;
    logic [pos_w-1:0]  zz_tab [blk_n];

    // zigzag index to raster position
    assign zz_tab = '{
        0,  1,  8, 16,  9,  2,  3, 10, 17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34, 27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36, 29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46, 53, 60, 61, 54, 47, 55, 62, 63
    };

    assign empty = (wptr_i == rptr_q);

    assign rptr_o    = rptr_q;
    assign q_o       = q_q;
    assign q_idx_o   = idx_q;
    assign q_valid_o = (state_q == rd_out);

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= rd_idle;
            req_q   <= 1'b0;
            rptr_q  <= '0;
            idx_q   <= '0;
        end else begin
            case (state_q)
                rd_idle: begin
                    if (!empty) begin
                        req_q   <= 1'b1;
                        state_q <= rd_req;
                    end
                end
                rd_req: begin
                    if (mem.ack) begin
                        req_q   <= 1'b0;
                        state_q <= rd_wait;
                    end
                end
                rd_wait: begin
                    // ack low again before the beat goes out
                    if (!mem.ack) begin
                        state_q <= rd_out;
                    end
                end
                rd_out: begin
                    if (!q_hold_i) begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= rd_idle;
                        if (idx_q == pos_w'(blk_n - 1)) begin
                            rptr_q <= rptr_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= rd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rd_idle && !empty) begin
            addr_q <= {rptr_q[ptr_w-2:0], zz_tab[idx_q]};
        end
        if (state_q == rd_req && mem.ack) begin
            q_q <= mem.rdata;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!resetn)
        (q_valid_o && q_hold_i) |=> ($stable(q_o) && $stable(q_idx_o)));

endmodule
